/* common/lsu_pkg.sv */
// ##################################################
// shared definitions for the load/store unit
// widths, load/store format codes and the op union
// imported by RTL and testbench alike
// ##################################################

package lsu_pkg;

    // data path and address widths
    localparam int XLEN           = 32;
    localparam int WORD_BYTES     = XLEN / 8;
    localparam int ALIGN_BITS     = $clog2(WORD_BYTES);
    localparam int WORD_ADDR_BITS = XLEN - ALIGN_BITS;

    // destination register index
    localparam int REG_BITS = 5;

    // load/store formats
    // bit 2 marks zero extension, bits 1:0 give the access size
    localparam logic [2:0] FMT_B  = 3'd0;
    localparam logic [2:0] FMT_H  = 3'd1;
    localparam logic [2:0] FMT_W  = 3'd2;
    localparam logic [2:0] FMT_BU = 3'd4;
    localparam logic [2:0] FMT_HU = 3'd5;

    // write sizes as seen through the mode view
    localparam logic [1:0] WSIZE_BYTE = 2'd0;
    localparam logic [1:0] WSIZE_HALF = 2'd1;
    localparam logic [1:0] WSIZE_WORD = 2'd2;

    // operation code of one instruction
    // request side reads mode, response side reads fmt
    typedef union packed {
        logic [2:0] fmt;
        struct packed {
            logic       is_unsigned;
            logic [1:0] wsize;
        } mode;
    } lsu_op_u;

endpackage

/* common/lsu_tag_if.sv */
// ##################################################
// one pending-load tag between the request path,
// the tag queue and the response path
// strobe is a push on one side and a pop on the other
// ##################################################

`timescale 1ns/100ps

interface lsu_tag_if import lsu_pkg::*; #(
    parameter int NUM_LANES = 4
) ();

    logic                                 strobe;
    logic [REG_BITS-1:0]                  rd;
    logic [NUM_LANES-1:0]                 tmask;
    lsu_op_u                              op;
    logic [NUM_LANES-1:0][ALIGN_BITS-1:0] align;
    logic                                 is_dup;

    // request path writes a tag for every issued load
    modport push_src (
        output strobe, rd, tmask, op, align, is_dup
    );

    modport push_dst (
        input  strobe, rd, tmask, op, align, is_dup
    );

    // queue presents its head, response side pops it
    modport pop_src (
        input  strobe,
        output rd, tmask, op, align, is_dup
    );

    modport pop_dst (
        output strobe,
        input  rd, tmask, op, align, is_dup
    );

endinterface

/* lsu_request/lsu_request.sv */
// ##################################################
// request path of the load/store unit
// per-lane address, duplicate collapse, byte enables
// and store data; combinational to the memory port
// ##################################################

`timescale 1ns/100ps

module lsu_request import lsu_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,

    input  logic                                     req_valid,
    output logic                                     req_ready,
    input  logic                                     req_is_store,
    input  logic                                     req_is_fence,
    input  lsu_op_u                                  req_op,
    input  logic [NUM_LANES-1:0]                     req_tmask,
    input  logic [NUM_LANES-1:0][XLEN-1:0]           req_base,
    input  logic [XLEN-1:0]                          req_imm,
    input  logic [NUM_LANES-1:0][XLEN-1:0]           req_store_data,
    input  logic [REG_BITS-1:0]                      req_rd,

    output logic                                     mem_req_valid,
    input  logic                                     mem_req_ready,
    output logic                                     mem_req_rw,
    output logic [NUM_LANES-1:0]                     mem_req_mask,
    output logic [NUM_LANES-1:0][WORD_ADDR_BITS-1:0] mem_req_addr,
    output logic [NUM_LANES-1:0][WORD_BYTES-1:0]     mem_req_byteen,
    output logic [NUM_LANES-1:0][XLEN-1:0]           mem_req_data,

    input  logic                                     queue_full,
    input  logic                                     queue_empty,

    lsu_tag_if.push_src                              tag_push
);

    logic [NUM_LANES-1:0][XLEN-1:0]       full_addr;
    logic [NUM_LANES-1:0][ALIGN_BITS-1:0] req_align;
    logic                                 is_dup;
    logic                                 is_load;
    logic                                 load_hold;
    logic                                 issue_en;

    // no issue until the cycle after reset is released
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_en <= 1'b0;
        end else begin
            issue_en <= 1'b1;
        end
    end

    // base + imm per lane, split into word address and byte offset
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            full_addr[i]    = req_base[i] + req_imm;
            req_align[i]    = full_addr[i][ALIGN_BITS-1:0];
            mem_req_addr[i] = full_addr[i][XLEN-1:ALIGN_BITS];
        end
    end

    // all active lanes on lane 0's address
    always_comb begin
        is_dup = req_tmask[0];
        for (int i = 1; i < NUM_LANES; i++) begin
            if (req_tmask[i] && (full_addr[i] != full_addr[0])) begin
                is_dup = 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            case (req_op.mode.wsize)
                WSIZE_BYTE: begin
                    mem_req_byteen[i] = WORD_BYTES'(1) << req_align[i];
                end
                WSIZE_HALF: begin
                    // halfword always on an aligned byte pair
                    mem_req_byteen[i] = WORD_BYTES'(3) << {req_align[i][ALIGN_BITS-1:1], 1'b0};
                end
                default: begin
                    mem_req_byteen[i] = '1;
                end
            endcase
            // store data moves up to its byte lane
            mem_req_data[i] = req_store_data[i] << {req_align[i], 3'b000};
        end
    end

    assign is_load   = ~req_is_store & ~req_is_fence;
    assign load_hold = is_load & queue_full;

    // fences never reach memory, they only wait for the queue to drain
    assign mem_req_valid = issue_en & req_valid & ~req_is_fence & ~load_hold;
    assign req_ready     = issue_en & (req_is_fence ? queue_empty : (mem_req_ready & ~load_hold));
    assign mem_req_rw    = req_is_store;
    assign mem_req_mask  = is_dup ? NUM_LANES'(1) : req_tmask;

    // tag travels beside the load, memory carries none
    assign tag_push.strobe = mem_req_valid & mem_req_ready & is_load;
    assign tag_push.rd     = req_rd;
    assign tag_push.tmask  = req_tmask;
    assign tag_push.op     = req_op;
    assign tag_push.align  = req_align;
    assign tag_push.is_dup = is_dup;

endmodule

/* design/lsu_tag_queue.sv */
// ##################################################
// FIFO of pending-load tags in memory-request order
// head entry formats the oldest outstanding response
// ##################################################

`timescale 1ns/100ps

module lsu_tag_queue import lsu_pkg::*; #(
    parameter int NUM_LANES   = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    output logic        empty,
    output logic        full,
    lsu_tag_if.push_dst tag_push,
    lsu_tag_if.pop_src  tag_pop
);

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    logic [REG_BITS-1:0]                  rd_mem    [QUEUE_DEPTH];
    logic [NUM_LANES-1:0]                 tmask_mem [QUEUE_DEPTH];
    lsu_op_u                              op_mem    [QUEUE_DEPTH];
    logic [NUM_LANES-1:0][ALIGN_BITS-1:0] align_mem [QUEUE_DEPTH];
    logic                                 dup_mem   [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    // wraps for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_BITS'(QUEUE_DEPTH));

    assign do_pop  = tag_pop.strobe & ~empty;
    assign do_push = tag_push.strobe & (~full | do_pop);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            rd_mem[wr_ptr]    <= tag_push.rd;
            tmask_mem[wr_ptr] <= tag_push.tmask;
            op_mem[wr_ptr]    <= tag_push.op;
            align_mem[wr_ptr] <= tag_push.align;
            dup_mem[wr_ptr]   <= tag_push.is_dup;
        end
    end

    assign tag_pop.rd     = rd_mem[rd_ptr];
    assign tag_pop.tmask  = tmask_mem[rd_ptr];
    assign tag_pop.op     = op_mem[rd_ptr];
    assign tag_pop.align  = align_mem[rd_ptr];
    assign tag_pop.is_dup = dup_mem[rd_ptr];

endmodule

/* lsu_response/lsu_response.sv */
// ##################################################
// response path of the load/store unit
// picks byte or halfword per lane, extends by format,
// broadcasts duplicates and registers the commit
// ##################################################

`timescale 1ns/100ps

module lsu_response import lsu_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           mem_rsp_valid,
    output logic                           mem_rsp_ready,
    input  logic [NUM_LANES-1:0][XLEN-1:0] mem_rsp_data,

    output logic                           commit_valid,
    input  logic                           commit_ready,
    output logic [REG_BITS-1:0]            commit_rd,
    output logic [NUM_LANES-1:0]           commit_tmask,
    output logic [NUM_LANES-1:0][XLEN-1:0] commit_data,

    lsu_tag_if.pop_dst                     tag_pop
);

    logic                           rsp_fire;
    logic [NUM_LANES-1:0][XLEN-1:0] rsp_data;

    // accept while the commit slot is free or draining
    assign mem_rsp_ready  = ~commit_valid | commit_ready;
    assign rsp_fire       = mem_rsp_valid & mem_rsp_ready;
    assign tag_pop.strobe = rsp_fire;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [XLEN-1:0]       word;
        logic [ALIGN_BITS-1:0] offset;
        logic [15:0]           half;
        logic [7:0]            byte_val;

        // duplicate warp reads lane 0 for everyone
        assign word     = tag_pop.is_dup ? mem_rsp_data[0] : mem_rsp_data[i];
        assign offset   = tag_pop.is_dup ? tag_pop.align[0] : tag_pop.align[i];
        assign half     = offset[1] ? word[31:16] : word[15:0];
        assign byte_val = offset[0] ? half[15:8] : half[7:0];

        always_comb begin
            case (tag_pop.op.fmt)
                FMT_B:   rsp_data[i] = {{(XLEN-8){byte_val[7]}}, byte_val};
                FMT_H:   rsp_data[i] = {{(XLEN-16){half[15]}}, half};
                FMT_BU:  rsp_data[i] = {{(XLEN-8){1'b0}}, byte_val};
                FMT_HU:  rsp_data[i] = {{(XLEN-16){1'b0}}, half};
                FMT_W:   rsp_data[i] = word;
                default: rsp_data[i] = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (rsp_fire) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    // full warp mask from the tag, so duplicates commit on every lane
    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            commit_rd    <= tag_pop.rd;
            commit_tmask <= tag_pop.tmask;
            commit_data  <= rsp_data;
        end
    end

endmodule

/* design/lsu_top.sv */
// ##################################################
// load/store unit top level
// request path, pending-load tag queue and response
// path behind plain instruction, memory and commit ports
// ##################################################

`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; #(
    parameter int NUM_LANES   = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,

    // instruction input
    input  logic                                     req_valid,
    output logic                                     req_ready,
    input  logic                                     req_is_store,
    input  logic                                     req_is_fence,
    input  lsu_op_u                                  req_op,
    input  logic [NUM_LANES-1:0]                     req_tmask,
    input  logic [NUM_LANES-1:0][XLEN-1:0]           req_base,
    input  logic [XLEN-1:0]                          req_imm,
    input  logic [NUM_LANES-1:0][XLEN-1:0]           req_store_data,
    input  logic [REG_BITS-1:0]                      req_rd,

    // memory request
    output logic                                     mem_req_valid,
    input  logic                                     mem_req_ready,
    output logic                                     mem_req_rw,
    output logic [NUM_LANES-1:0]                     mem_req_mask,
    output logic [NUM_LANES-1:0][WORD_ADDR_BITS-1:0] mem_req_addr,
    output logic [NUM_LANES-1:0][WORD_BYTES-1:0]     mem_req_byteen,
    output logic [NUM_LANES-1:0][XLEN-1:0]           mem_req_data,

    // memory response
    input  logic                                     mem_rsp_valid,
    output logic                                     mem_rsp_ready,
    input  logic [NUM_LANES-1:0][XLEN-1:0]           mem_rsp_data,

    // commit
    output logic                                     commit_valid,
    input  logic                                     commit_ready,
    output logic [REG_BITS-1:0]                      commit_rd,
    output logic [NUM_LANES-1:0]                     commit_tmask,
    output logic [NUM_LANES-1:0][XLEN-1:0]           commit_data
);

    logic queue_empty;
    logic queue_full;

    lsu_tag_if #(.NUM_LANES(NUM_LANES)) tag_push ();
    lsu_tag_if #(.NUM_LANES(NUM_LANES)) tag_pop ();

    lsu_request #(
        .NUM_LANES (NUM_LANES)
    ) request_unit (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_is_store   (req_is_store),
        .req_is_fence   (req_is_fence),
        .req_op         (req_op),
        .req_tmask      (req_tmask),
        .req_base       (req_base),
        .req_imm        (req_imm),
        .req_store_data (req_store_data),
        .req_rd         (req_rd),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_rw     (mem_req_rw),
        .mem_req_mask   (mem_req_mask),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .queue_full     (queue_full),
        .queue_empty    (queue_empty),
        .tag_push       (tag_push)
    );

    lsu_tag_queue #(
        .NUM_LANES   (NUM_LANES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) tag_queue (
        .clk      (clk),
        .reset    (reset),
        .empty    (queue_empty),
        .full     (queue_full),
        .tag_push (tag_push),
        .tag_pop  (tag_pop)
    );

    lsu_response #(
        .NUM_LANES (NUM_LANES)
    ) response_unit (
        .clk           (clk),
        .reset         (reset),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit_rd     (commit_rd),
        .commit_tmask  (commit_tmask),
        .commit_data   (commit_data),
        .tag_pop       (tag_pop)
    );

endmodule

/* test/lsu_mem_model.sv */
// ##################################################
// byte-addressed memory behind the LSU memory port
// random request ready, in-order load responses
// after 0 to 3 cycles, driven from the rnd input
// ##################################################

`timescale 1ns/100ps

module lsu_mem_model import lsu_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [31:0]                              rnd,
    input  logic                                     mem_req_valid,
    output logic                                     mem_req_ready,
    input  logic                                     mem_req_rw,
    input  logic [NUM_LANES-1:0]                     mem_req_mask,
    input  logic [NUM_LANES-1:0][WORD_ADDR_BITS-1:0] mem_req_addr,
    input  logic [NUM_LANES-1:0][WORD_BYTES-1:0]     mem_req_byteen,
    input  logic [NUM_LANES-1:0][XLEN-1:0]           mem_req_data,
    output logic                                     mem_rsp_valid,
    input  logic                                     mem_rsp_ready,
    output logic [NUM_LANES-1:0][XLEN-1:0]           mem_rsp_data
);

    logic [XLEN-1:0]                mem [256];
    logic [NUM_LANES-1:0][XLEN-1:0] rsp_q [$];
    int                             due_q [$];
    int                             cycle;

    initial begin
        // fill pattern from the whole word address
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};
        end
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        cycle         = 0;
    end

    always @(posedge clk) begin
        logic [NUM_LANES-1:0][XLEN-1:0] rdata;
        if (reset) begin
            rsp_q.delete();
            due_q.delete();
        end else begin
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    rdata[i] = mem[mem_req_addr[i][7:0]];
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (mem_req_rw && mem_req_mask[i] && mem_req_byteen[i][b]) begin
                            mem[mem_req_addr[i][7:0]][8*b +: 8] = mem_req_data[i][8*b +: 8];
                        end
                    end
                end
                if (!mem_req_rw) begin
                    rsp_q.push_back(rdata);
                    due_q.push_back(cycle + 1 + int'(rnd[3:2]));
                end
            end
            cycle++;
        end
        #2;
        mem_req_ready = rnd[0] | rnd[1];
        mem_rsp_valid = (rsp_q.size() > 0) && (due_q[0] <= cycle);
        mem_rsp_data  = (rsp_q.size() > 0) ? rsp_q[0] : '0;
    end

endmodule

/* test/lsu_tb.sv */
// ##################################################
// testbench for the load/store unit
// word stores and loads, then random mixed traffic
// checked against a byte shadow of memory
// ##################################################

`timescale 1ns/100ps

module lsu_tb import lsu_pkg::*;;

    localparam int N_LANES = 4;
    localparam int N_RAND  = 80;
    localparam int NUM_OPS = 32 + N_RAND;

    logic clk, reset;
    logic req_valid, req_ready, req_is_store, req_is_fence;
    lsu_op_u req_op;
    logic [N_LANES-1:0] req_tmask;
    logic [N_LANES-1:0][XLEN-1:0] req_base, req_store_data;
    logic [XLEN-1:0] req_imm;
    logic [REG_BITS-1:0] req_rd;
    logic mem_req_valid, mem_req_ready, mem_req_rw;
    logic [N_LANES-1:0] mem_req_mask;
    logic [N_LANES-1:0][WORD_ADDR_BITS-1:0] mem_req_addr;
    logic [N_LANES-1:0][WORD_BYTES-1:0] mem_req_byteen;
    logic [N_LANES-1:0][XLEN-1:0] mem_req_data, mem_rsp_data, commit_data;
    logic mem_rsp_valid, mem_rsp_ready, commit_valid, commit_ready;
    logic [REG_BITS-1:0] commit_rd;
    logic [N_LANES-1:0] commit_tmask;

    logic [31:0] seed = 32'h2264_dba7;
    logic [31:0] cyc_rs = 32'h2264_dba7;
    logic [31:0] cur_addr [N_LANES];
    logic [7:0] shadow [256];
    logic [REG_BITS-1:0] exp_rd [$];
    logic [N_LANES-1:0] exp_tmask [$];
    logic [N_LANES-1:0][XLEN-1:0] exp_data [$];
    int outstanding = 0;
    logic started = 1'b0;

    lsu_top #(.NUM_LANES(N_LANES), .QUEUE_DEPTH(4)) UUT (.*);

    lsu_mem_model #(.NUM_LANES(N_LANES)) mem_model (.rnd(cyc_rs), .*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic plain_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    // little-endian read from the shadow, extended by format
    function automatic logic [31:0] load_value(input logic [31:0] a, input logic [2:0] fmt);
        logic [31:0] v;
        int nb;
        nb = 1 << fmt[1:0];
        v  = '0;
        for (int k = 0; k < nb; k++) begin
            v[8*k +: 8] = shadow[a[7:0] + k];
        end
        if (!fmt[2] && nb == 1) begin
            v = {{24{v[7]}}, v[7:0]};
        end else if (!fmt[2] && nb == 2) begin
            v = {{16{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    task automatic check_request();
        logic dup;
        logic [N_LANES-1:0] mask;
        logic [WORD_BYTES-1:0] be;
        logic [N_LANES-1:0][XLEN-1:0] ldata;
        logic [7:0] sbyte;
        int nb;
        dup = req_tmask[0];
        for (int i = 1; i < N_LANES; i++) begin
            if (req_tmask[i] && cur_addr[i] != cur_addr[0]) dup = 1'b0;
        end
        mask = dup ? N_LANES'(1) : req_tmask;
        nb   = 1 << req_op.fmt[1:0];
        assert (mem_req_mask == mask) else value_error("request mask", mask, mem_req_mask);
        assert (mem_req_rw == req_is_store) else value_error("request rw", req_is_store, mem_req_rw);
        for (int i = 0; i < N_LANES; i++) begin
            ldata[i] = load_value(dup ? cur_addr[0] : cur_addr[i], req_op.fmt);
            if (mask[i]) begin
                assert (mem_req_addr[i] == cur_addr[i][31:2])
                    else value_error("request address", cur_addr[i][31:2], mem_req_addr[i]);
            end
            if (req_is_store && mask[i]) begin
                be = WORD_BYTES'((1 << nb) - 1) << cur_addr[i][1:0];
                assert (mem_req_byteen[i] == be) else value_error("byte enable", be, mem_req_byteen[i]);
                for (int k = 0; k < nb; k++) begin
                    shadow[cur_addr[i][7:0] + k] = req_store_data[i][8*k +: 8];
                    sbyte = mem_req_data[i][8*(cur_addr[i][1:0] + k) +: 8];
                    assert (sbyte == req_store_data[i][8*k +: 8])
                        else value_error("store data", req_store_data[i][8*k +: 8], sbyte);
                end
            end
        end
        if (!req_is_store) begin
            exp_rd.push_back(req_rd);
            exp_tmask.push_back(req_tmask);
            exp_data.push_back(ldata);
            outstanding++;
        end
    endtask

    task automatic check_commit();
        logic [N_LANES-1:0][XLEN-1:0] d;
        if (exp_rd.size() == 0) plain_error("commit with no load outstanding");
        d = exp_data.pop_front();
        assert (commit_rd == exp_rd[0]) else value_error("commit rd", exp_rd[0], commit_rd);
        assert (commit_tmask == exp_tmask[0])
            else value_error("commit tmask", exp_tmask[0], commit_tmask);
        for (int i = 0; i < N_LANES; i++) begin
            if (exp_tmask[0][i]) begin
                assert (commit_data[i] == d[i]) else value_error("load data", d[i], commit_data[i]);
            end
        end
        void'(exp_rd.pop_front());
        void'(exp_tmask.pop_front());
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (!started) begin
                assert (!mem_req_valid && !commit_valid)
                    else plain_error("request or commit seen before the first instruction");
            end
            if (mem_req_valid && mem_req_ready) check_request();
            if (mem_rsp_valid && mem_rsp_ready) outstanding--;
            if (commit_valid && commit_ready) check_commit();
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_data)
            && $stable(commit_rd) && $stable(commit_tmask))
        else plain_error("commit outputs changed while stalled");
    assert property (@(posedge clk) disable iff (reset)
        req_valid && req_is_fence && outstanding != 0 |-> !req_ready)
        else plain_error("fence accepted with loads outstanding");
    assert property (@(posedge clk) disable iff (reset)
        req_valid && req_is_fence && outstanding == 0 |-> req_ready)
        else plain_error("fence held with no load outstanding");
    assert property (@(posedge clk) disable iff (reset)
        req_valid && req_is_fence |-> !mem_req_valid)
        else plain_error("fence issued a memory request");

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc_rs <= xorshift(cyc_rs);

    always @(posedge clk) begin
        #2;
        commit_ready = cyc_rs[8] | cyc_rs[12];
    end

    initial begin
        #(NUM_OPS * 40 * 20 + 200);
        $display("watchdog timeout, the run did not finish in time");
        $display("Checks failed");
        $fatal(1);
    end

    task automatic send_op(input logic store, input logic fence, input logic [2:0] fmt,
                           input logic [N_LANES-1:0] tmask);
        logic [31:0] imm;
        logic [31:0] r;
        imm = next_rand() & 32'hff;
        r   = next_rand();
        for (int i = 0; i < N_LANES; i++) begin
            req_base[i]       = cur_addr[i] - imm;
            req_store_data[i] = next_rand();
        end
        req_is_store = store;
        req_is_fence = fence;
        req_op.fmt   = fmt;
        req_imm      = imm;
        req_tmask    = tmask;
        req_rd       = r[REG_BITS-1:0];
        req_valid    = 1'b1;
        started      = 1'b1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    // random aligned addresses, all equal for a duplicate warp
    task automatic pick_addrs(input logic [2:0] fmt, input logic dup);
        int nb;
        nb = 1 << fmt[1:0];
        for (int i = 0; i < N_LANES; i++) begin
            cur_addr[i] = (next_rand() % 256) & ~(nb - 1);
            if (dup && i > 0) cur_addr[i] = cur_addr[0];
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0] fmt;
        logic [2:0] fmts [5];
        fmts = '{FMT_B, FMT_H, FMT_W, FMT_BU, FMT_HU};
        reset = 1'b1;
        req_valid = 1'b0;
        req_is_store = 1'b0;
        req_is_fence = 1'b0;
        req_op = '0;
        req_tmask = '0;
        req_base = '0;
        req_imm = '0;
        req_store_data = '0;
        req_rd = '0;
        commit_ready = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        // fill words 0..63, then read them back
        for (int pass = 0; pass < 2; pass++) begin
            for (int w = 0; w < 16; w++) begin
                for (int i = 0; i < N_LANES; i++) cur_addr[i] = (w * 4 + i) * 4;
                send_op(pass == 0, 1'b0, FMT_W, 4'hf);
            end
        end
        for (int n = 0; n < N_RAND; n++) begin
            r = next_rand();
            fmt = (r[2:0] < 3) ? fmts[r[5:4] % 3] : fmts[r[8:6] % 5];
            pick_addrs(fmt, r[10:9] == 2'd0);
            if (r[2:0] == 3'd0) begin
                send_op(1'b0, 1'b1, FMT_W, 4'hf);
            end else begin
                send_op(r[2:0] < 3, 1'b0, fmt, r[15:12] | (r[17:16] == 0 ? 4'h0 : 4'h1));
            end
        end
        while (outstanding != 0 || exp_rd.size() != 0) @(posedge clk);
        @(posedge clk);
        if (!commit_valid) begin
            $display("All checks passed");
            $finish;
        end else begin
            plain_error("commit still valid after the last load retired");
        end
    end

endmodule

/* src.f */
common/lsu_pkg.sv
common/lsu_tag_if.sv
lsu_request/lsu_request.sv
design/lsu_tag_queue.sv
lsu_response/lsu_response.sv
design/lsu_top.sv
test/lsu_mem_model.sv
test/lsu_tb.sv
